// ==== src.f ====
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_queue.sv
hdl/lsu_arbiter.sv
hdl/lsu_txn_counter.sv
hdl/lsu_resp_path.sv
hdl/lsu_top.sv
testbench/lsu_mem_model.sv
testbench/lsu_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module lsu_tb -f src.f -Mdir obj_dir -o lsu_tb
	./obj_dir/lsu_tb | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/lsu_tb.sv ====
`include "lsu_defs.svh"

module lsu_tb import lsu_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam addr_t ERR_ADDR = 32'h0000_0bad;
	localparam int N_T1 = 16;
	localparam int N_T2 = 8;
	localparam int N_T3 = 24;
	localparam int N_T4 = 12;
	localparam int N_WIN = 6;
	localparam int N_T5 = 8;
	// Every client request of the run including the error read
	localparam int TOTAL = 2*N_T1 + N_T2 + 2*N_T3 + 16 + N_T4 + 1 + N_WIN + 2*N_T5;
	localparam int LIMIT = 20*TOTAL + 200;

	logic clk;
	logic nrst;
	logic i_reinit;
	logic o_busy;
	logic o_err;
	logic i_rd_valid;
	logic o_rd_ready;
	rd_req_t i_rd_req;
	logic i_wr_valid;
	logic o_wr_ready;
	wr_req_t i_wr_req;
	logic o_mreq_valid;
	logic mreq_ready;
	mem_req_t o_mreq;
	logic mrsp_valid;
	logic o_mrsp_ready;
	mem_rsp_t mrsp;
	logic o_rrs_valid;
	logic i_rrs_ready;
	rd_rsp_t o_rrs;

	// Stimulus controls
	logic bp_en;
	logic withhold;
	logic rrs_bp;
	logic rrs_bp_now;
	logic disabled_window;
	int inflight;
	int max_inflight;

	integer seed = 31038;
	int cycles = 0;
	int err_pulses = 0;
	int mreq_in_window = 0;
	// Shadow of memory contents as the client's own writes leave it
	data_t shadow [addr_t];
	rd_rsp_t expected [$];
	rd_rsp_t exp_rsp;

	lsu_top dut_i (
		.clk(clk), .nrst(nrst), .i_reinit(i_reinit), .o_busy(o_busy), .o_err(o_err),
		.i_rd_valid(i_rd_valid), .o_rd_ready(o_rd_ready), .i_rd_req(i_rd_req),
		.i_wr_valid(i_wr_valid), .o_wr_ready(o_wr_ready), .i_wr_req(i_wr_req),
		.o_mreq_valid(o_mreq_valid), .i_mreq_ready(mreq_ready), .o_mreq(o_mreq),
		.i_mrsp_valid(mrsp_valid), .o_mrsp_ready(o_mrsp_ready), .i_mrsp(mrsp),
		.o_rrs_valid(o_rrs_valid), .i_rrs_ready(i_rrs_ready), .o_rrs(o_rrs)
	);

	lsu_mem_model #(.ERR_ADDR(ERR_ADDR)) mem_i (
		.clk(clk), .nrst(nrst), .i_bp_en(bp_en), .i_withhold(withhold),
		.i_mreq_valid(o_mreq_valid), .o_mreq_ready(mreq_ready), .i_mreq(o_mreq),
		.o_mrsp_valid(mrsp_valid), .i_mrsp_ready(o_mrsp_ready), .o_mrsp(mrsp),
		.o_inflight(inflight), .o_max_inflight(max_inflight)
	);

	always #2 clk = ~clk;

	task automatic abort_run(input string why);
		$display("ERROR at %0t: %s", $time, why);
		$display("Simulation failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check(input string name, input logic [63:0] actual, input logic [63:0] want);
		if (actual !== want)
		begin
			$display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, want);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// Expected read data comes from the shadow or from the fill pattern of an unwritten word
	function automatic data_t ref_read(input addr_t addr);
		if (shadow.exists(addr))
			return shadow[addr];
		return {addr, addr} ^ 64'h5eed_0000_c0de_ffff;
	endfunction

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic send_read(input thread_t th, input addr_t addr, input bit track);
		rd_rsp_t exp;
		exp.th = th;
		exp.data = ref_read(addr);
		if (track)
			expected.push_back(exp);
		i_rd_req.th = th;
		i_rd_req.addr = addr;
		i_rd_valid = 1'b1;
		do
			@(posedge clk);
		while (!o_rd_ready);
		#1;
		i_rd_valid = 1'b0;
	endtask

	task automatic send_write(input thread_t th, input addr_t addr, input wen_t wen,
		input data_t data, input bit track);
		data_t merged;
		merged = ref_read(addr);
		for (int w = 0; w < `LSU_WEN_W; w++)
			if (wen[w])
				merged[w*32 +: 32] = data[w*32 +: 32];
		if (track)
			shadow[addr] = merged;
		i_wr_req.th = th;
		i_wr_req.addr = addr;
		i_wr_req.wen = wen;
		i_wr_req.data = data;
		i_wr_valid = 1'b1;
		do
			@(posedge clk);
		while (!o_wr_ready);
		#1;
		i_wr_valid = 1'b0;
	endtask

	task automatic wait_drained();
		do
			@(posedge clk);
		while (o_busy);
		#1;
	endtask

	// Client response ready toggles at random while back-pressure is on
	always @(posedge clk)
	begin
		rrs_bp_now = rrs_bp;
		#1;
		i_rrs_ready = !rrs_bp_now || (($random(seed) & 1) != 0);
	end

	// Each client response must match the oldest outstanding read
	always @(posedge clk)
	begin
		if (nrst && o_rrs_valid && i_rrs_ready)
		begin
			if (expected.size() == 0)
				abort_run("a read response arrived that no tracked read asked for");
			else
			begin
				exp_rsp = expected.pop_front();
				check("o_rrs.th", 64'(o_rrs.th), 64'(exp_rsp.th));
				check("o_rrs.data", o_rrs.data, exp_rsp.data);
			end
		end
	end

	// Pulse and window monitors plus the overall cycle limit
	always @(posedge clk)
	begin
		cycles++;
		if (nrst && o_err)
			err_pulses++;
		if (disabled_window && o_mreq_valid)
			mreq_in_window++;
		if (cycles >= LIMIT)
			abort_run("timeout, the traffic did not finish within the cycle limit");
	end

	initial
	begin
		clk = 1'b0;
		nrst = 1'b0;
		i_reinit = 1'b0;
		i_rd_valid = 1'b0;
		i_rd_req = '0;
		i_wr_valid = 1'b0;
		i_wr_req = '0;
		i_rrs_ready = 1'b0;
		bp_en = 1'b0;
		withhold = 1'b0;
		rrs_bp = 1'b0;
		disabled_window = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		nrst = 1'b1;

		// Partial writes, then the merged words read back
		for (int i = 0; i < N_T1; i++)
			send_write(thread_t'(i), 32'h100 + i, wen_t'($random(seed)),
				{$random(seed), $random(seed)}, 1'b1);
		wait_drained();
		for (int i = 0; i < N_T1; i++)
			send_read(thread_t'(i), 32'h100 + i, 1'b1);

		// Never written words give the fill pattern in issue order
		for (int i = 0; i < N_T2; i++)
			send_read(thread_t'(7 - i), 32'h8000 + 7*i, 1'b1);
		wait_drained();

		// Mixed bursts under back-pressure on disjoint read and write addresses
		bp_en = 1'b1;
		rrs_bp = 1'b1;
		fork
			for (int i = 0; i < N_T3; i++)
			begin
				send_write(thread_t'(i), 32'h3000 + ($random(seed) & 15),
					wen_t'($random(seed)), {$random(seed), $random(seed)}, 1'b1);
				idle($unsigned($random(seed)) % 3);
			end
			for (int i = 0; i < N_T3; i++)
			begin
				send_read(thread_t'(i + 3), 32'h100 + ($random(seed) & 15), 1'b1);
				idle($unsigned($random(seed)) % 3);
			end
		join
		wait_drained();
		for (int i = 0; i < 16; i++)
			send_read(thread_t'(i), 32'h3000 + i, 1'b1);
		wait_drained();

		// Memory sits on its answers until the in-flight limit is hit
		withhold = 1'b1;
		for (int i = 0; i < N_T4; i++)
			send_read(thread_t'(i), 32'h100 + (i % 16), 1'b1);
		while (inflight < `LSU_MAX_INFLIGHT)
			idle(1);
		idle(10);
		check("max_inflight", max_inflight, `LSU_MAX_INFLIGHT);
		withhold = 1'b0;
		wait_drained();

		// Error answer disables the unit until reinit
		send_read(thread_t'(5), ERR_ADDR, 1'b0);
		while (err_pulses == 0)
			idle(1);
		wait_drained();
		disabled_window = 1'b1;
		for (int i = 0; i < N_WIN; i++)
			if (i % 3 == 2)
				send_write(thread_t'(i), 32'h7000 + i, 2'b11,
					{$random(seed), $random(seed)}, 1'b0);
			else
				send_read(thread_t'(i), 32'h100 + i, 1'b0);
		idle(8);
		check("mreq_in_window", mreq_in_window, 0);
		check("err_pulses", err_pulses, 1);
		disabled_window = 1'b0;
		i_reinit = 1'b1;
		idle(1);
		i_reinit = 1'b0;

		// Normal traffic again once reinit has cleared the unit
		for (int i = 0; i < N_T5; i++)
			send_write(thread_t'(i), 32'h6000 + i, wen_t'($random(seed)),
				{$random(seed), $random(seed)}, 1'b1);
		wait_drained();
		for (int i = 0; i < N_T5; i++)
			send_read(thread_t'(i), 32'h6000 + i, 1'b1);
		wait_drained();

		check("pending_responses", expected.size(), 0);
		check("o_rrs_valid", o_rrs_valid, 0);
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== testbench/lsu_mem_model.sv ====
`include "lsu_defs.svh"

module lsu_mem_model import lsu_pkg::*;
#(
	parameter addr_t ERR_ADDR = 32'h0000_0bad
)
(
	input logic clk,
	input logic nrst,
	input logic i_bp_en,
	input logic i_withhold,
	input logic i_mreq_valid,
	output logic o_mreq_ready,
	input mem_req_t i_mreq,
	output logic o_mrsp_valid,
	input logic i_mrsp_ready,
	output mem_rsp_t o_mrsp,
	output int o_inflight,
	output int o_max_inflight
);

	timeunit 1ns;
	timeprecision 100ps;

	// Backing store, only words that were written are present
	data_t storage [addr_t];
	// Answers waiting their turn and the cycle each may leave on
	mem_rsp_t pend_rsp [$];
	int pend_due [$];

	integer seed = 31038;
	int cycle = 0;
	logic run_now;
	logic req_fire;
	logic rsp_fire;
	logic bp_now;
	logic hold_now;
	mem_rsp_t rsp;
	data_t word;

	// Unwritten words read back as their address folded with a constant
	function automatic data_t fill_word(input addr_t addr);
		return {addr, addr} ^ 64'h5eed_0000_c0de_ffff;
	endfunction

	initial
	begin
		o_mreq_ready = 1'b0;
		o_mrsp_valid = 1'b0;
		o_mrsp = '0;
		o_inflight = 0;
		o_max_inflight = 0;
	end

	always @(posedge clk)
	begin
		// Handshakes and controls are sampled on the edge
		run_now = nrst;
		req_fire = nrst && i_mreq_valid && o_mreq_ready;
		rsp_fire = nrst && o_mrsp_valid && i_mrsp_ready;
		bp_now = i_bp_en;
		hold_now = i_withhold;
		cycle++;
		if (req_fire)
		begin
			word = storage.exists(i_mreq.addr) ? storage[i_mreq.addr] : fill_word(i_mreq.addr);
			// Each enable bit guards one 32-bit word of the beat
			if (i_mreq.wr)
			begin
				for (int w = 0; w < `LSU_WEN_W; w++)
					if (i_mreq.wen[w])
						word[w*32 +: 32] = i_mreq.data[w*32 +: 32];
				storage[i_mreq.addr] = word;
			end
			rsp.wr = i_mreq.wr;
			rsp.th = i_mreq.th;
			rsp.err = (i_mreq.addr == ERR_ADDR);
			rsp.data = i_mreq.wr ? '0 : word;
			pend_rsp.push_back(rsp);
			pend_due.push_back(cycle + ($random(seed) & 3));
		end
		#1;
		// Observer of requests that still wait for an answer
		o_inflight = o_inflight + int'(req_fire) - int'(rsp_fire);
		if (o_inflight > o_max_inflight)
			o_max_inflight = o_inflight;
		if (rsp_fire)
			o_mrsp_valid = 1'b0;
		// Answers leave strictly in request order
		if (!o_mrsp_valid && !hold_now && pend_rsp.size() != 0 && pend_due[0] <= cycle)
		begin
			o_mrsp = pend_rsp.pop_front();
			void'(pend_due.pop_front());
			o_mrsp_valid = 1'b1;
		end
		o_mreq_ready = run_now && (!bp_now || (($random(seed) & 3) != 0));
	end

endmodule

// ==== hdl/lsu_top.sv ====
`include "lsu_defs.svh"

module lsu_top import lsu_pkg::*;
(
	input logic clk,
	input logic nrst,
	input logic i_reinit,
	output logic o_busy,
	output logic o_err,
	input logic i_rd_valid,
	output logic o_rd_ready,
	input rd_req_t i_rd_req,
	input logic i_wr_valid,
	output logic o_wr_ready,
	input wr_req_t i_wr_req,
	output logic o_mreq_valid,
	input logic i_mreq_ready,
	output mem_req_t o_mreq,
	input logic i_mrsp_valid,
	output logic o_mrsp_ready,
	input mem_rsp_t i_mrsp,
	output logic o_rrs_valid,
	input logic i_rrs_ready,
	output rd_rsp_t o_rrs
);

	// Read request queue
	logic rd_push;
	logic rd_pop;
	logic rd_empty;
	logic rd_full;
	rd_req_t rd_head;

	// Write request queue
	logic wr_push;
	logic wr_pop;
	logic wr_empty;
	logic wr_full;
	wr_req_t wr_head;

	// Read response queue
	logic rs_push;
	logic rs_empty;
	logic rs_full;
	rd_rsp_t rs_data;

	logic disabled;
	logic inflight_full;
	logic inflight_idle;
	logic req_fire;
	logic rsp_fire;

	// A disabled unit swallows client requests without storing them
	assign o_rd_ready = disabled || !rd_full;
	assign o_wr_ready = disabled || !wr_full;
	assign rd_push = i_rd_valid && !rd_full && !disabled;
	assign wr_push = i_wr_valid && !wr_full && !disabled;

	assign req_fire = o_mreq_valid && i_mreq_ready;
	assign o_rrs_valid = !rs_empty;

	// The arbiter register and the response stage also hold work
	assign o_busy = !inflight_idle || !rd_empty || !wr_empty || !rs_empty ||
		o_mreq_valid || rs_push;

	lsu_queue #(.T(rd_req_t), .DEPTH_LOG2(`LSU_RQ_DEPTH_LOG2)) rd_queue (
		.clk(clk), .nrst(nrst), .i_flush(disabled),
		.i_push(rd_push), .i_data(i_rd_req), .i_pop(rd_pop),
		.o_data(rd_head), .o_empty(rd_empty), .o_full(rd_full)
	);

	lsu_queue #(.T(wr_req_t), .DEPTH_LOG2(`LSU_WQ_DEPTH_LOG2)) wr_queue (
		.clk(clk), .nrst(nrst), .i_flush(disabled),
		.i_push(wr_push), .i_data(i_wr_req), .i_pop(wr_pop),
		.o_data(wr_head), .o_empty(wr_empty), .o_full(wr_full)
	);

	// Responses already staged for the client are never flushed
	lsu_queue #(.T(rd_rsp_t), .DEPTH_LOG2(`LSU_RS_DEPTH_LOG2)) rs_queue (
		.clk(clk), .nrst(nrst), .i_flush(1'b0),
		.i_push(rs_push), .i_data(rs_data), .i_pop(o_rrs_valid && i_rrs_ready),
		.o_data(o_rrs), .o_empty(rs_empty), .o_full(rs_full)
	);

	lsu_arbiter arbiter_i (
		.clk(clk), .nrst(nrst), .i_hold(disabled),
		.i_rd_empty(rd_empty), .i_rd_req(rd_head), .o_rd_pop(rd_pop),
		.i_wr_empty(wr_empty), .i_wr_req(wr_head), .o_wr_pop(wr_pop),
		.i_inflight_full(inflight_full),
		.o_mreq_valid(o_mreq_valid), .i_mreq_ready(i_mreq_ready), .o_mreq(o_mreq)
	);

	lsu_txn_counter counter_i (
		.clk(clk), .nrst(nrst), .i_req_fire(req_fire), .i_rsp_fire(rsp_fire),
		.o_full(inflight_full), .o_idle(inflight_idle)
	);

	lsu_resp_path resp_i (
		.clk(clk), .nrst(nrst), .i_reinit(i_reinit),
		.i_mrsp_valid(i_mrsp_valid), .i_mrsp(i_mrsp), .o_mrsp_ready(o_mrsp_ready),
		.o_rsp_fire(rsp_fire), .i_rs_full(rs_full), .o_rs_push(rs_push),
		.o_rs_data(rs_data), .o_disabled(disabled), .o_err(o_err)
	);

endmodule

// ==== hdl/lsu_resp_path.sv ====
module lsu_resp_path import lsu_pkg::*;
(
	input logic clk,
	input logic nrst,
	input logic i_reinit,
	input logic i_mrsp_valid,
	input mem_rsp_t i_mrsp,
	output logic o_mrsp_ready,
	output logic o_rsp_fire,
	input logic i_rs_full,
	output logic o_rs_push,
	output rd_rsp_t o_rs_data,
	output logic o_disabled,
	output logic o_err
);

	logic disabled_q;
	logic err_q;

	// One read answer staged on its way into the response queue
	logic stage_valid;
	rd_rsp_t stage_data;

	// Answer accepted while enabled, split by kind
	logic rsp_bad;
	logic rsp_keep;

	// Back-pressure only when the stage is stuck behind a full queue
	assign o_mrsp_ready = disabled_q || !(stage_valid && i_rs_full);
	assign o_rsp_fire = i_mrsp_valid && o_mrsp_ready;

	assign rsp_bad = o_rsp_fire && !disabled_q && i_mrsp.err;
	// Write answers are consumed here and go no further
	assign rsp_keep = o_rsp_fire && !disabled_q && !i_mrsp.err && !i_mrsp.wr;

	assign o_rs_push = stage_valid && !i_rs_full && !disabled_q;
	assign o_rs_data = stage_data;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			disabled_q <= 1'b0;
			err_q <= 1'b0;
			stage_valid <= 1'b0;
		end
		else
		begin
			err_q <= rsp_bad;
			// An error outranks a reinit arriving on the same edge
			if (rsp_bad)
				disabled_q <= 1'b1;
			else if (i_reinit)
				disabled_q <= 1'b0;
			if (disabled_q)
				stage_valid <= 1'b0;
			else
				stage_valid <= rsp_keep || (stage_valid && !o_rs_push);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rsp_keep)
		begin
			stage_data.th <= i_mrsp.th;
			stage_data.data <= i_mrsp.data;
		end
	end

	assign o_disabled = disabled_q;
	assign o_err = err_q;

endmodule

// ==== hdl/lsu_txn_counter.sv ====
`include "lsu_defs.svh"

module lsu_txn_counter import lsu_pkg::*;
(
	input logic clk,
	input logic nrst,
	input logic i_req_fire,
	input logic i_rsp_fire,
	output logic o_full,
	output logic o_idle
);

	// Requests on the channel that still wait for an answer
	inflight_t count;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			count <= '0;
		else
		begin
			// Issue and answer on the same edge leave the count as it is
			case ({i_req_fire, i_rsp_fire})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

	// A request leaving now already takes a slot, so the arbiter
	// must not reload its register into the last one
	assign o_full = (int'(count) + int'(i_req_fire)) >= `LSU_MAX_INFLIGHT;
	assign o_idle = (count == '0);

	// Memory answers only what was issued before
	a_no_rsp_idle: assert property (@(posedge clk) disable iff (!nrst)
		i_rsp_fire |-> count != '0);

	// The arbiter never pushes past the in-flight limit
	a_no_req_full: assert property (@(posedge clk) disable iff (!nrst)
		i_req_fire |-> int'(count) < `LSU_MAX_INFLIGHT);

endmodule

// ==== hdl/lsu_arbiter.sv ====
module lsu_arbiter import lsu_pkg::*;
(
	input logic clk,
	input logic nrst,
	input logic i_hold,
	input logic i_rd_empty,
	input rd_req_t i_rd_req,
	output logic o_rd_pop,
	input logic i_wr_empty,
	input wr_req_t i_wr_req,
	output logic o_wr_pop,
	input logic i_inflight_full,
	output logic o_mreq_valid,
	input logic i_mreq_ready,
	output mem_req_t o_mreq
);

	arb_state_t state_q;
	arb_state_t state_d;

	// Output register and its valid flag
	logic valid_q;
	mem_req_t mreq_q;

	// Queue chosen for this cycle
	logic sel_rd;
	logic sel_wr;
	// Register can take a new entry on this edge
	logic can_load;

	mem_req_t rd_mreq;
	mem_req_t wr_mreq;

	// Reads leave enable and data at zero
	always_comb
	begin
		rd_mreq = '0;
		rd_mreq.wr = 1'b0;
		rd_mreq.th = i_rd_req.th;
		rd_mreq.addr = i_rd_req.addr;
		wr_mreq.wr = 1'b1;
		wr_mreq.th = i_wr_req.th;
		wr_mreq.addr = i_wr_req.addr;
		wr_mreq.wen = i_wr_req.wen;
		wr_mreq.data = i_wr_req.data;
	end

	// Stay with the last queue, idle and write states favour writes
	always_comb
	begin
		case (state_q)
		ARB_READ, ARB_READ_STALL:
		begin
			sel_rd = !i_rd_empty;
			sel_wr = i_rd_empty && !i_wr_empty;
		end
		default:
		begin
			sel_wr = !i_wr_empty;
			sel_rd = i_wr_empty && !i_rd_empty;
		end
		endcase
	end

	// Register is free or being taken, and there is room in flight
	assign can_load = (!valid_q || i_mreq_ready) && !i_inflight_full && !i_hold;
	assign o_wr_pop = sel_wr && can_load;
	assign o_rd_pop = sel_rd && can_load;

	always_comb
	begin
		if (i_hold)
			state_d = ARB_IDLE;
		else if (sel_wr)
			state_d = i_inflight_full ? ARB_WRITE_STALL : ARB_WRITE;
		else if (sel_rd)
			state_d = i_inflight_full ? ARB_READ_STALL : ARB_READ;
		else
			state_d = ARB_IDLE;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state_q <= ARB_IDLE;
			valid_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			// Disabled unit drops whatever sits in the register
			if (i_hold)
				valid_q <= 1'b0;
			else if (o_rd_pop || o_wr_pop)
				valid_q <= 1'b1;
			else if (i_mreq_ready)
				valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (o_wr_pop)
			mreq_q <= wr_mreq;
		else if (o_rd_pop)
			mreq_q <= rd_mreq;
	end

	assign o_mreq_valid = valid_q;
	assign o_mreq = mreq_q;

	// A stalled request stays on the channel unchanged until taken
	a_mreq_stable: assert property (@(posedge clk) disable iff (!nrst || i_hold)
		o_mreq_valid && !i_mreq_ready |=> o_mreq_valid && $stable(o_mreq));

endmodule

// ==== hdl/lsu_queue.sv ====
module lsu_queue #(
	parameter type T = logic,
	parameter int DEPTH_LOG2 = 2
)
(
	input logic clk,
	input logic nrst,
	input logic i_flush,
	input logic i_push,
	input T i_data,
	input logic i_pop,
	output T o_data,
	output logic o_empty,
	output logic o_full
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	// Storage array, written only on push
	T mem [DEPTH];

	// The extra top bit flips on every wrap of the buffer
	logic [DEPTH_LOG2:0] wr_ptr;
	logic [DEPTH_LOG2:0] rd_ptr;

	// Equal pointers mean empty, same index on different laps means full
	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full = (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]) &&
		(wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]);

	// The head is read straight from the array
	assign o_data = mem[rd_ptr[DEPTH_LOG2-1:0]];

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (i_flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_push)
			mem[wr_ptr[DEPTH_LOG2-1:0]] <= i_data;
	end

	// The producer must watch the full flag
	a_no_push_full: assert property (@(posedge clk) disable iff (!nrst || i_flush)
		i_push |-> !o_full);

	// The consumer must watch the empty flag
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!nrst || i_flush)
		i_pop |-> !o_empty);

endmodule

// ==== hdl/lsu_pkg.sv ====
`include "lsu_defs.svh"

package lsu_pkg;

	typedef logic [`LSU_ADDR_W-1:0] addr_t;
	typedef logic [`LSU_DATA_W-1:0] data_t;
	typedef logic [`LSU_TH_W-1:0] thread_t;
	typedef logic [`LSU_WEN_W-1:0] wen_t;
	// Wide enough to hold zero up to the in-flight limit
	typedef logic [$clog2(`LSU_MAX_INFLIGHT+1)-1:0] inflight_t;

	typedef struct packed {
		thread_t th;
		addr_t addr;
	} rd_req_t;

	typedef struct packed {
		thread_t th;
		addr_t addr;
		wen_t wen;
		data_t data;
	} wr_req_t;

	// Reads carry zero enable and zero data
	typedef struct packed {
		logic wr;
		thread_t th;
		addr_t addr;
		wen_t wen;
		data_t data;
	} mem_req_t;

	typedef struct packed {
		logic wr;
		thread_t th;
		logic err;
		data_t data;
	} mem_rsp_t;

	typedef struct packed {
		thread_t th;
		data_t data;
	} rd_rsp_t;

	// One-hot arbiter states
	typedef enum logic [4:0] {
		ARB_IDLE = 5'b00001,
		ARB_READ = 5'b00010,
		ARB_WRITE = 5'b00100,
		ARB_READ_STALL = 5'b01000,
		ARB_WRITE_STALL = 5'b10000
	} arb_state_t;

endpackage

// ==== hdl/lsu_defs.svh ====
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Width of a memory word address
`define LSU_ADDR_W 32
// Width of one data beat
`define LSU_DATA_W 64
// Width of a thread id
`define LSU_TH_W 3
// Number of 32-bit words in a beat, one enable bit each
`define LSU_WEN_W 2

// Queue depths as powers of two
`define LSU_RQ_DEPTH_LOG2 3
`define LSU_WQ_DEPTH_LOG2 2
`define LSU_RS_DEPTH_LOG2 3

// Most requests that may wait for an answer at once
`define LSU_MAX_INFLIGHT 8

`endif
